// File: mem_pkg.sv
package mem_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // line geometry
    ////////////////////////////////////////////////////////////////////////////

    localparam int ADDR_BITS      = 32;
    localparam int OFFSET_BITS    = 5;                          // 32 byte line.
    localparam int LINE_ADDR_BITS = ADDR_BITS - OFFSET_BITS;
    localparam int WORD_BITS      = 32;
    localparam int LINE_WORDS     = 8;
    localparam int LINE_BITS      = WORD_BITS * LINE_WORDS;

    typedef logic [LINE_ADDR_BITS-1:0] line_addr_t;
    typedef logic [LINE_BITS-1:0]      line_data_t;

    ////////////////////////////////////////////////////////////////////////////
    // one side's view of the memory port
    ////////////////////////////////////////////////////////////////////////////

    typedef struct packed
    {
        line_addr_t addr;
        line_data_t wdata;                                      // reads ignore it.
    } line_req_t;

endpackage : mem_pkg

// File: arbiter_pkg.sv
package arbiter_pkg;

    // who holds the memory port.
    typedef enum logic [1:0]
    {
        idle,
        i_cache,
        d_cache
    } arb_state_t;

    // request mux select.
    typedef logic owner_t;

    localparam owner_t OWNER_I = 1'b0;
    localparam owner_t OWNER_D = 1'b1;

endpackage : arbiter_pkg

// File: arbiter_control.sv
module arbiter_control
    import arbiter_pkg::*;
(
    input  logic   clk,
    input  logic   rst,
    input  logic   i_read,
    input  logic   d_read,
    input  logic   d_write,
    input  logic   mem_resp,

    output logic   mem_read,
    output logic   mem_write,
    output logic   i_resp,
    output logic   d_resp,
    output owner_t owner
);

    arb_state_t state;
    arb_state_t next_state;
    logic       d_active;

    assign d_active = d_read | d_write;

    ////////////////////////////////////////////////////////////////////////////
    // ownership register
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            state <= idle;
        end
        else
        begin
            state <= next_state;
        end
    end

    always_comb
    begin
        next_state = state;

        unique case (state)
            idle:
            begin
                if (i_read)
                begin
                    next_state = i_cache;                       // i side wins a tie.
                end
                else if (d_active)
                begin
                    next_state = d_cache;
                end
            end

            i_cache:
            begin
                if (mem_resp)
                begin
                    next_state = idle;
                end
            end

            d_cache:
            begin
                // held across back to back requests.
                if (!d_active)
                begin
                    next_state = idle;
                end
            end

            default:
            begin
                next_state = idle;
            end
        endcase
    end

    ////////////////////////////////////////////////////////////////////////////
    // strobe gating and response steering
    ////////////////////////////////////////////////////////////////////////////

    always_comb
    begin
        mem_read  = 1'b0;
        mem_write = 1'b0;
        i_resp    = 1'b0;
        d_resp    = 1'b0;
        owner     = OWNER_I;

        unique case (state)
            i_cache:
            begin
                mem_read = i_read;
                i_resp   = mem_resp;
            end

            d_cache:
            begin
                mem_read  = d_read;
                mem_write = d_write;
                d_resp    = mem_resp;
                owner     = OWNER_D;
            end

            default:
            begin
                owner = OWNER_I;                                // port idle.
            end
        endcase
    end

endmodule : arbiter_control

// File: cache_arbiter.sv
module cache_arbiter
    import mem_pkg::*;
    import arbiter_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  logic      i_read,
    input  logic      d_read,
    input  logic      d_write,
    input  line_req_t i_req,
    input  line_req_t d_req,
    input  logic      mem_resp,

    output logic      mem_read,
    output logic      mem_write,
    output logic      i_resp,
    output logic      d_resp,
    output line_req_t mem_req
);

    owner_t owner;

    arbiter_control arbiter_control_inst
    (
        .clk       (clk),
        .rst       (rst),
        .i_read    (i_read),
        .d_read    (d_read),
        .d_write   (d_write),
        .mem_resp  (mem_resp),
        .mem_read  (mem_read),
        .mem_write (mem_write),
        .i_resp    (i_resp),
        .d_resp    (d_resp),
        .owner     (owner)
    );

    // request mux, strobes are already gated.
    always_comb
    begin
        if (owner == OWNER_D)
        begin
            mem_req = d_req;
        end
        else
        begin
            mem_req = i_req;
        end
    end

endmodule : cache_arbiter

// File: line_memory.sv
module line_memory
    import mem_pkg::*;
#(
    parameter int mem_latency     = 4,
    parameter int mem_depth_lines = 64
)
(
    input  logic       clk,
    input  logic       rst,
    input  logic       mem_read,
    input  logic       mem_write,
    input  line_req_t  mem_req,

    output logic       mem_resp,
    output line_data_t rdata
);

    localparam int index_bits = (mem_depth_lines > 1) ? $clog2(mem_depth_lines) : 1;
    localparam int count_bits = $clog2(mem_latency + 1);

    typedef enum logic [1:0]
    {
        mem_ready,
        mem_busy,
        mem_recover
    } mem_state_t;

    typedef logic [index_bits-1:0] line_index_t;
    typedef logic [count_bits-1:0] count_t;

    line_data_t  mem_array [mem_depth_lines];
    mem_state_t  state;
    count_t      count;
    line_index_t index;
    logic        request;

    assign request = mem_read | mem_write;
    assign index   = mem_req.addr[index_bits-1:0];

    ////////////////////////////////////////////////////////////////////////////
    // latency counter
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            state <= mem_ready;
            count <= '0;
        end
        else
        begin
            unique case (state)
                mem_ready:
                begin
                    if (request)
                    begin
                        state <= mem_busy;
                        count <= count_t'(1);
                    end
                end

                mem_busy:
                begin
                    if (mem_resp)
                    begin
                        state <= mem_recover;
                    end
                    else
                    begin
                        count <= count + 1'b1;
                    end
                end

                default:
                begin
                    state <= mem_ready;                         // one idle cycle.
                end
            endcase
        end
    end

    assign mem_resp = (state == mem_busy) && (count == count_t'(mem_latency));

    ////////////////////////////////////////////////////////////////////////////
    // line storage
    ////////////////////////////////////////////////////////////////////////////

    initial
    begin
        for (int n = 0; n < mem_depth_lines; n++)
        begin
            for (int w = 0; w < LINE_WORDS; w++)
            begin
                mem_array[n][w*WORD_BITS +: WORD_BITS] = {16'(n), 16'(w)};
            end
        end
    end

    always @(posedge clk)
    begin
        if (mem_resp && mem_write)
        begin
            mem_array[index] <= mem_req.wdata;
        end
    end

    assign rdata = mem_array[index];                            // valid with mem_resp.

endmodule : line_memory

// File: mem_subsystem_top.sv
module mem_subsystem_top
    import mem_pkg::*;
#(
    parameter int mem_latency     = 4,
    parameter int mem_depth_lines = 64
)
(
    input  logic       clk,
    input  logic       rst,

    input  logic       i_read,
    input  line_req_t  i_req,
    output logic       i_resp,

    input  logic       d_read,
    input  logic       d_write,
    input  line_req_t  d_req,
    output logic       d_resp,

    output line_data_t rdata
);

    logic      mem_read;
    logic      mem_write;
    logic      mem_resp;
    line_req_t mem_req;

    cache_arbiter cache_arbiter_inst
    (
        .clk       (clk),
        .rst       (rst),
        .i_read    (i_read),
        .d_read    (d_read),
        .d_write   (d_write),
        .i_req     (i_req),
        .d_req     (d_req),
        .mem_resp  (mem_resp),
        .mem_read  (mem_read),
        .mem_write (mem_write),
        .i_resp    (i_resp),
        .d_resp    (d_resp),
        .mem_req   (mem_req)
    );

    line_memory #(
        .mem_latency     (mem_latency),
        .mem_depth_lines (mem_depth_lines)
    ) line_memory_inst
    (
        .clk       (clk),
        .rst       (rst),
        .mem_read  (mem_read),
        .mem_write (mem_write),
        .mem_req   (mem_req),
        .mem_resp  (mem_resp),
        .rdata     (rdata)
    );

endmodule : mem_subsystem_top

// File: tb_mem_subsystem_tasks.svh
`ifndef TB_MEM_SUBSYSTEM_TASKS_SVH
`define TB_MEM_SUBSYSTEM_TASKS_SVH

////////////////////////////////////////////////////////////////////////////
// reference model
////////////////////////////////////////////////////////////////////////////

function automatic int line_index(line_addr_t addr);
    return int'(addr[index_bits-1:0]);
endfunction

// word w of line n holds n over w.
function automatic line_data_t pattern_line(int n);
    line_data_t line;
    for (int w = 0; w < LINE_WORDS; w++)
    begin
        line[w*WORD_BITS +: WORD_BITS] = {16'(n), 16'(w)};
    end
    return line;
endfunction

function automatic line_data_t expected_line(line_addr_t addr);
    return shadow[line_index(addr)];
endfunction

////////////////////////////////////////////////////////////////////////////
// client drivers
////////////////////////////////////////////////////////////////////////////

task automatic i_access(line_addr_t addr);
    int start;
    @(negedge clk);
    start         = i_count;
    i_req.addr    = addr;
    i_req.wdata   = '0;
    i_busy        = 1'b1;
    i_read        = 1'b1;
    i_raise_cycle = cycle;
    do
        @(posedge clk);
    while (i_count == start);                                   // held through the pulse.
    i_busy = 1'b0;
    @(negedge clk);
    i_read = 1'b0;
endtask

task automatic d_access(logic write, line_addr_t addr, line_data_t wdata, logic hold);
    int start;
    @(negedge clk);
    start       = d_count;
    d_req.addr  = addr;
    d_req.wdata = wdata;
    d_busy      = 1'b1;
    d_read      = !write;
    d_write     = write;
    do
        @(posedge clk);
    while (d_count == start);
    d_busy = 1'b0;
    if (!hold)
    begin
        @(negedge clk);
        d_read  = 1'b0;
        d_write = 1'b0;
    end
endtask

////////////////////////////////////////////////////////////////////////////
// compare tasks
////////////////////////////////////////////////////////////////////////////

task automatic check_line(string name, line_data_t expected, line_data_t actual);
    if (actual !== expected)
    begin
        $display("Error %s expected %h actual %h", name, expected, actual);
        errors++;
    end
endtask

task automatic check_resp_owner(string name, logic expected_d, logic actual_d);
    if (actual_d !== expected_d)
    begin
        $display("Error %s expected %s side actual %s side", name,
                 expected_d ? "d" : "i", actual_d ? "d" : "i");
        errors++;
    end
endtask

task automatic check_count(string name, int expected, int actual);
    if (actual != expected)
    begin
        $display("Error %s expected %0d actual %0d", name, expected, actual);
        errors++;
    end
endtask

`endif

// File: tb_mem_subsystem.sv
module tb_mem_subsystem
    import mem_pkg::*;
;

    localparam int mem_latency     = 4;
    localparam int mem_depth_lines = 64;
    localparam int index_bits      = $clog2(mem_depth_lines);
    localparam int num_tests       = 5;
    localparam int num_random      = 40;
    localparam int timeout_cycles  = num_tests * num_random * (mem_latency + 4) + 10;

    logic       clk;
    logic       rst;
    logic       i_read;
    line_req_t  i_req;
    logic       i_resp;
    logic       d_read;
    logic       d_write;
    line_req_t  d_req;
    logic       d_resp;
    line_data_t rdata;

    line_data_t shadow [mem_depth_lines];
    int         cycle;
    int         errors;
    int         test_errors;
    int         tests_passed;
    int         tests_failed;
    string      test_name;
    logic       i_busy;
    logic       d_busy;
    int         i_count;
    int         d_count;
    int         i_last_cycle;
    int         d_last_cycle;
    int         i_raise_cycle;
    line_data_t d_last_rdata;

    `include "tb_mem_subsystem_tasks.svh"

    mem_subsystem_top #(
        .mem_latency     (mem_latency),
        .mem_depth_lines (mem_depth_lines)
    ) mem_subsystem_top_inst
    (
        .clk     (clk),
        .rst     (rst),
        .i_read  (i_read),
        .i_req   (i_req),
        .i_resp  (i_resp),
        .d_read  (d_read),
        .d_write (d_write),
        .d_req   (d_req),
        .d_resp  (d_resp),
        .rdata   (rdata)
    );

    initial
    begin
        clk = 1'b0;
        forever
        begin
            #5 clk = ~clk;
        end
    end

    initial
    begin
        cycle = 0;
        forever
        begin
            @(posedge clk);
            cycle++;
        end
    end

    initial
    begin
        while (cycle < timeout_cycles)
        begin
            @(posedge clk);
        end
        $display("timeout, the run went past %0d cycles", timeout_cycles);
        $display("Simulation failed");
        $finish;
    end

    ////////////////////////////////////////////////////////////////////////////
    // response monitor
    ////////////////////////////////////////////////////////////////////////////

    initial
    begin
        i_count = 0;
        d_count = 0;
        forever
        begin
            @(negedge clk);
            if (i_resp && d_resp)
            begin
                $display("both sides got a response in one cycle during %s", test_name);
                errors++;
            end
            if (i_resp)
            begin
                if (!i_busy)
                begin
                    $display("instruction response with no request pending in %s", test_name);
                    errors++;
                end
                else
                begin
                    check_line(test_name, expected_line(i_req.addr), rdata);
                end
                i_count++;
                i_last_cycle = cycle;
            end
            if (d_resp)
            begin
                if (!d_busy)
                begin
                    $display("data response with no request pending in %s", test_name);
                    errors++;
                end
                else if (d_write)
                begin
                    shadow[line_index(d_req.addr)] = d_req.wdata;   // write lands at the pulse.
                end
                else
                begin
                    check_line(test_name, expected_line(d_req.addr), rdata);
                    d_last_rdata = rdata;
                end
                d_count++;
                d_last_cycle = cycle;
            end
        end
    end

    task automatic start_test(string name);
        test_name   = name;
        test_errors = errors;
    endtask

    task automatic finish_test();
        if (errors == test_errors)
        begin
            tests_passed++;
            $display("test %s ok", test_name);
        end
        else
        begin
            tests_failed++;
            $display("test %s failed with %0d errors", test_name, errors - test_errors);
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // test sequence
    ////////////////////////////////////////////////////////////////////////////

    initial
    begin
        logic       side [num_random];
        logic       op   [num_random];
        line_addr_t addr [num_random];
        line_data_t wd   [num_random];
        line_data_t line;
        int         n_i;
        int         n_d;
        int         i_base;
        int         d_base;

        void'($urandom(9));
        rst = 1'b1;
        i_read = 1'b0;
        i_req = '0;
        d_read = 1'b0;
        d_write = 1'b0;
        d_req = '0;
        i_busy = 1'b0;
        d_busy = 1'b0;
        errors = 0;
        tests_passed = 0;
        tests_failed = 0;
        for (int n = 0; n < mem_depth_lines; n++)
        begin
            shadow[n] = pattern_line(n);
        end
        repeat (10) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        start_test("reset_quiet");
        check_count(test_name, 0, int'(i_resp) + int'(d_resp));
        repeat (20) @(negedge clk);
        check_count(test_name, 0, i_count + d_count);
        finish_test();

        start_test("i_read_alone");
        d_base = d_count;
        i_access(line_addr_t'(3));
        check_count(test_name, 1 + mem_latency, i_last_cycle - i_raise_cycle);
        check_count(test_name, d_base, d_count);
        finish_test();

        start_test("d_write_then_read");
        for (int w = 0; w < LINE_WORDS; w++)
        begin
            line[w*WORD_BITS +: WORD_BITS] = $urandom();
        end
        fork
            begin
                d_access(1'b1, line_addr_t'(7), line, 1'b1);
                d_access(1'b0, line_addr_t'(7), '0, 1'b0);
            end
            begin
                repeat (2) @(negedge clk);
                i_access(line_addr_t'(12));
            end
        join
        check_line(test_name, line, d_last_rdata);
        check_resp_owner(test_name, 1'b1, d_last_cycle < i_last_cycle);
        finish_test();

        start_test("tie_from_idle");
        fork
            i_access(line_addr_t'(5));
            d_access(1'b0, line_addr_t'(9), '0, 1'b0);
        join
        check_resp_owner(test_name, 1'b0, d_last_cycle < i_last_cycle);
        finish_test();

        start_test("random_mixed");
        n_i = 0;
        n_d = 0;
        for (int k = 0; k < num_random; k++)
        begin
            side[k] = 1'($urandom_range(0, 1));
            op[k]   = 1'($urandom_range(0, 1));
            addr[k] = line_addr_t'($urandom_range(0, 2 * mem_depth_lines - 1));
            for (int w = 0; w < LINE_WORDS; w++)
            begin
                wd[k][w*WORD_BITS +: WORD_BITS] = $urandom();
            end
            if (side[k])
            begin
                n_d++;
            end
            else
            begin
                n_i++;
            end
        end
        i_base = i_count;
        d_base = d_count;
        fork
            for (int k = 0; k < num_random; k++)
            begin
                if (!side[k])
                begin
                    i_access(addr[k]);
                end
            end
            for (int k = 0; k < num_random; k++)
            begin
                if (side[k])
                begin
                    d_access(op[k], addr[k], wd[k], 1'b0);
                end
            end
        join
        check_count(test_name, n_i, i_count - i_base);
        check_count(test_name, n_d, d_count - d_base);
        finish_test();

        $display("tests passed %0d, tests failed %0d, errors %0d",
                 tests_passed, tests_failed, errors);
        if (errors == 0)
        begin
            $display("Simulation passed");
        end
        else
        begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule : tb_mem_subsystem

// File: build.f
+incdir+.
mem_pkg.sv
arbiter_pkg.sv
arbiter_control.sv
cache_arbiter.sv
line_memory.sv
mem_subsystem_top.sv
tb_mem_subsystem.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_mem_subsystem
FILE_LIST ?= build.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing -j 0
PASS_TEXT ?= Simulation passed

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILE_LIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_TEXT)"

clean:
	rm -rf $(OBJ_DIR)
